//--- hw/mshr_macros.svh
`ifndef MSHR_MACROS_SVH
`define MSHR_MACROS_SVH

// number of miss entries in the ring, must be a power of two
`define MSHR_DEPTH 8

// cache line address bits
`define MSHR_ADDR_W 28

`endif

//--- hw/mshr_pkg.sv
`include "mshr_macros.svh"

package mshr_pkg;

    localparam int SLOT_W = $clog2(`MSHR_DEPTH);

    typedef logic [`MSHR_ADDR_W-1:0] addr_t;   // line address
    typedef logic [SLOT_W-1:0] slot_t;         // ring index
    typedef logic [SLOT_W:0] cnt_t;            // 0 .. depth inclusive
    typedef logic [`MSHR_DEPTH-1:0] vec_t;     // one bit per entry

    // cache op code, only the store code matters here
    typedef logic [2:0] op_t;
    localparam op_t OP_STORE = 3'd2;

    // match key, same line as load and as store are distinct
    typedef struct packed {
        addr_t addr;
        logic store;
    } mshr_key_t;

endpackage

//--- hw/miss_if.sv
// one new allocation per cycle, tracking stage to issue stage
interface miss_if;
    import mshr_pkg::*;

    logic valid;    // strobe, one cycle per allocation
    addr_t addr;
    logic store;
    slot_t slot;    // ring slot just written

    modport src (
        output valid,
        output addr,
        output store,
        output slot
    );

    modport dst (
        input valid,
        input addr,
        input store,
        input slot
    );

endinterface

//--- hw/mshr_queue.sv
`include "mshr_macros.svh"

module mshr_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc,
    input  mshr_pkg::mshr_key_t alloc_key,
    input  mshr_pkg::mshr_key_t probe_key,
    input  mshr_pkg::mshr_key_t rsp_key,
    input  logic                rsp_valid,
    output mshr_pkg::vec_t      probe_match,
    output mshr_pkg::vec_t      rsp_match,
    output mshr_pkg::slot_t     wr_slot,
    output mshr_pkg::cnt_t      count
);
    import mshr_pkg::*;

    mshr_key_t keys [`MSHR_DEPTH];
    vec_t valid;
    vec_t done;
    slot_t head;    // oldest entry
    logic retire;
    vec_t retire_vec;
    vec_t alloc_vec;
    vec_t done_set;

    // only the head may leave, and only once it is finished
    assign retire = valid[head] && done[head];

    assign retire_vec = retire ? (vec_t'(1) << head) : '0;
    assign alloc_vec = alloc ? (vec_t'(1) << wr_slot) : '0;
    assign done_set = rsp_valid ? rsp_match : '0;

    always_comb begin
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            probe_match[i] = valid[i] && (keys[i] == probe_key);
            // a finished entry never takes a second response
            rsp_match[i] = valid[i] && !done[i] && (keys[i] == rsp_key);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            keys[wr_slot] <= alloc_key;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            done <= '0;
        end else begin
            valid <= (valid & ~retire_vec) | alloc_vec;
            done <= (done & ~retire_vec & ~alloc_vec) | done_set;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            wr_slot <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head + slot_t'(1);   // wraps at depth
            end
            if (alloc) begin
                wr_slot <= wr_slot + slot_t'(1);
            end
            count <= count + cnt_t'(alloc) - cnt_t'(retire);
        end
    end

endmodule

//--- hw/mshr_track.sv
`include "mshr_macros.svh"

module mshr_track (
    input  logic                clk,
    input  logic                rst,
    input  logic                acc_valid,
    input  mshr_pkg::mshr_key_t acc_key,
    input  logic                l2_rsp_valid,
    input  logic                l2_rsp_store,
    input  mshr_pkg::addr_t     l2_rsp_addr,
    output logic                mshr_hit,
    output mshr_pkg::slot_t     hit_slot,
    output logic                mshr_fin,
    output mshr_pkg::slot_t     fin_slot,
    output logic                mshr_full,
    miss_if.src                 alloc_out
);
    import mshr_pkg::*;

    mshr_key_t rsp_key;
    vec_t probe_match;
    vec_t rsp_match;
    slot_t wr_slot;
    cnt_t count;
    cnt_t occupied;
    logic alloc;

    // match vectors are one-hot, so OR of the set indices gives the slot
    function automatic slot_t onehot_to_slot(input vec_t vec);
        slot_t s;
        s = '0;
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            if (vec[i]) begin
                s = s | slot_t'(i);
            end
        end
        return s;
    endfunction

    assign rsp_key.addr = l2_rsp_addr;
    assign rsp_key.store = l2_rsp_store;

    assign mshr_hit = acc_valid && (|probe_match);
    assign hit_slot = onehot_to_slot(probe_match);
    assign alloc = acc_valid && !(|probe_match);   // new line, take a slot

    assign mshr_fin = l2_rsp_valid && (|rsp_match);
    assign fin_slot = onehot_to_slot(rsp_match);

    // stage 1 counts too, it may still allocate
    assign occupied = count + cnt_t'(acc_valid);
    assign mshr_full = (occupied >= cnt_t'(`MSHR_DEPTH));

    assign alloc_out.valid = alloc;
    assign alloc_out.addr = acc_key.addr;
    assign alloc_out.store = acc_key.store;
    assign alloc_out.slot = wr_slot;

    mshr_queue mshr_queue_i (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc),
        .alloc_key   (acc_key),
        .probe_key   (acc_key),
        .rsp_key     (rsp_key),
        .rsp_valid   (l2_rsp_valid),
        .probe_match (probe_match),
        .rsp_match   (rsp_match),
        .wr_slot     (wr_slot),
        .count       (count)
    );

endmodule

//--- hw/miss_accept.sv
module miss_accept (
    input  logic                clk,
    input  logic                rst,
    input  logic                miss_valid,
    input  mshr_pkg::op_t       miss_op,
    input  mshr_pkg::addr_t     miss_addr,
    input  logic                mshr_full,
    output logic                acc_valid,
    output mshr_pkg::mshr_key_t acc_key
);
    import mshr_pkg::*;

    mshr_key_t miss_key;
    logic take;

    // anything that is not a store is tracked as a load
    assign miss_key.addr = miss_addr;
    assign miss_key.store = (miss_op == OP_STORE);

    // dropped while full, no replay
    assign take = miss_valid && !mshr_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc_key <= miss_key;
        end
    end

endmodule

//--- hw/l2_issue.sv
module l2_issue (
    input  logic            clk,
    input  logic            rst,
    miss_if.dst             alloc_in,
    output logic            l2_req_valid,
    output mshr_pkg::addr_t l2_req_addr,
    output logic            l2_req_store,
    output mshr_pkg::slot_t l2_req_slot
);

    // L2 never stalls, so every allocation becomes a single strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            l2_req_valid <= 1'b0;
        end else begin
            l2_req_valid <= alloc_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_in.valid) begin
            l2_req_addr <= alloc_in.addr;
            l2_req_store <= alloc_in.store;
            l2_req_slot <= alloc_in.slot;   // tag, comes back as the finish slot
        end
    end

endmodule

//--- hw/mshr_top.sv
module mshr_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            miss_valid,
    input  mshr_pkg::op_t   miss_op,
    input  mshr_pkg::addr_t miss_addr,
    input  logic            l2_rsp_valid,
    input  logic            l2_rsp_store,
    input  mshr_pkg::addr_t l2_rsp_addr,
    output logic            mshr_hit,
    output mshr_pkg::slot_t hit_slot,
    output logic            mshr_fin,
    output mshr_pkg::slot_t fin_slot,
    output logic            mshr_full,
    output logic            l2_req_valid,
    output mshr_pkg::addr_t l2_req_addr,
    output logic            l2_req_store,
    output mshr_pkg::slot_t l2_req_slot
);
    import mshr_pkg::*;

    logic acc_valid;
    mshr_key_t acc_key;

    miss_if alloc_if ();

    miss_accept miss_accept_i (
        .clk        (clk),
        .rst        (rst),
        .miss_valid (miss_valid),
        .miss_op    (miss_op),
        .miss_addr  (miss_addr),
        .mshr_full  (mshr_full),
        .acc_valid  (acc_valid),
        .acc_key    (acc_key)
    );

    mshr_track mshr_track_i (
        .clk          (clk),
        .rst          (rst),
        .acc_valid    (acc_valid),
        .acc_key      (acc_key),
        .l2_rsp_valid (l2_rsp_valid),
        .l2_rsp_store (l2_rsp_store),
        .l2_rsp_addr  (l2_rsp_addr),
        .mshr_hit     (mshr_hit),
        .hit_slot     (hit_slot),
        .mshr_fin     (mshr_fin),
        .fin_slot     (fin_slot),
        .mshr_full    (mshr_full),
        .alloc_out    (alloc_if.src)
    );

    l2_issue l2_issue_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_in     (alloc_if.dst),
        .l2_req_valid (l2_req_valid),
        .l2_req_addr  (l2_req_addr),
        .l2_req_store (l2_req_store),
        .l2_req_slot  (l2_req_slot)
    );

endmodule

//--- tests/mshr_tb_checks.svh
`ifndef MSHR_TB_CHECKS_SVH
`define MSHR_TB_CHECKS_SVH

task automatic check_hit(input int t, input logic got, input slot_t got_slot,
                         input logic want, input slot_t want_slot);
    checks[t]++;
    if (got !== want) begin
        errors[t]++;
        $display("[ERROR] mshr_hit: got %h, expected %h at %0t", got, want, $time);
    end else if (want && (got_slot !== want_slot)) begin
        errors[t]++;
        $display("[ERROR] hit_slot: got %h, expected %h at %0t", got_slot, want_slot, $time);
    end
endtask

task automatic check_fin(input int t, input logic got, input slot_t got_slot,
                         input logic want, input slot_t want_slot);
    checks[t]++;
    if (got !== want) begin
        errors[t]++;
        $display("[ERROR] mshr_fin: got %h, expected %h at %0t", got, want, $time);
    end else if (want && (got_slot !== want_slot)) begin
        errors[t]++;
        $display("[ERROR] fin_slot: got %h, expected %h at %0t", got_slot, want_slot, $time);
    end
endtask

// fields only matter on a request cycle
task automatic check_req(input int t, input logic got, input addr_t got_addr,
                         input logic got_store, input slot_t got_slot,
                         input logic want, input mshr_key_t want_key, input slot_t want_slot);
    checks[t]++;
    if (got !== want) begin
        errors[t]++;
        $display("[ERROR] l2_req_valid: got %h, expected %h at %0t", got, want, $time);
    end else if (want) begin
        if (got_addr !== want_key.addr) begin
            errors[t]++;
            $display("[ERROR] l2_req_addr: got %h, expected %h at %0t",
                     got_addr, want_key.addr, $time);
        end
        if (got_store !== want_key.store) begin
            errors[t]++;
            $display("[ERROR] l2_req_store: got %h, expected %h at %0t",
                     got_store, want_key.store, $time);
        end
        if (got_slot !== want_slot) begin
            errors[t]++;
            $display("[ERROR] l2_req_slot: got %h, expected %h at %0t",
                     got_slot, want_slot, $time);
        end
    end
endtask

task automatic check_full(input int t, input logic got, input logic want);
    checks[t]++;
    if (got !== want) begin
        errors[t]++;
        $display("[ERROR] mshr_full: got %h, expected %h at %0t", got, want, $time);
    end
endtask

`endif

//--- tests/mshr_tb.sv
`include "mshr_macros.svh"

module mshr_tb;
    import mshr_pkg::*;

    localparam int N_CYCLES = 3000;
    localparam int N_TESTS = 5;
    localparam addr_t POOL_BASE = 28'h0ab_c000;

    logic clk = 1'b0;
    logic rst;
    logic miss_valid;
    op_t miss_op;
    addr_t miss_addr;
    logic l2_rsp_valid;
    logic l2_rsp_store;
    addr_t l2_rsp_addr;
    logic mshr_hit;
    slot_t hit_slot;
    logic mshr_fin;
    slot_t fin_slot;
    logic mshr_full;
    logic l2_req_valid;
    addr_t l2_req_addr;
    logic l2_req_store;
    slot_t l2_req_slot;

    int errors [N_TESTS];
    int checks [N_TESTS];
    string test_name [N_TESTS];
    int n_hit;
    int n_fin;
    int n_stale;
    int n_alloc;
    int n_full;
    int n_drop;

    // reference ring, stage-1 register and pending L2 request
    mshr_key_t m_key [`MSHR_DEPTH];
    logic m_valid [`MSHR_DEPTH];
    logic m_done [`MSHR_DEPTH];
    slot_t m_head;
    int alloc_cnt;
    logic s1_valid;
    mshr_key_t s1_key;
    logic q_valid;
    mshr_key_t q_key;
    slot_t q_slot;

    logic [31:0] lfsr = 32'h5204;

    `include "mshr_tb_checks.svh"

    mshr_top mshr_top_i (
        .clk          (clk),
        .rst          (rst),
        .miss_valid   (miss_valid),
        .miss_op      (miss_op),
        .miss_addr    (miss_addr),
        .l2_rsp_valid (l2_rsp_valid),
        .l2_rsp_store (l2_rsp_store),
        .l2_rsp_addr  (l2_rsp_addr),
        .mshr_hit     (mshr_hit),
        .hit_slot     (hit_slot),
        .mshr_fin     (mshr_fin),
        .fin_slot     (fin_slot),
        .mshr_full    (mshr_full),
        .l2_req_valid (l2_req_valid),
        .l2_req_addr  (l2_req_addr),
        .l2_req_store (l2_req_store),
        .l2_req_slot  (l2_req_slot)
    );

    always #2 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic note_failure(input int t, input string what);
        errors[t]++;
        $display("test %s: %s", test_name[t], what);
    endtask

    task automatic drive_random();
        slot_t idx;
        miss_valid = (rand_bits(2) != 0);   // three cycles in four
        miss_op = (rand_bits(1) != 0) ? OP_STORE : op_t'(rand_bits(3));
        miss_addr = POOL_BASE + addr_t'(rand_bits(3));   // small pool so lines repeat
        l2_rsp_valid = (rand_bits(3) < 3);
        if (rand_bits(1) != 0) begin
            idx = slot_t'(rand_bits(3));
            l2_rsp_addr = m_key[idx].addr;   // may be done or retired already
            l2_rsp_store = m_key[idx].store;
        end else begin
            l2_rsp_addr = POOL_BASE + addr_t'(rand_bits(4));   // upper half never missed
            l2_rsp_store = (rand_bits(1) != 0);
        end
    endtask

    task automatic model_cycle();
        int cnt;
        int hit_i;
        int fin_i;
        logic e_full;
        logic alloc;
        logic retire;
        slot_t w;
        mshr_key_t rk;
        cnt = 0;
        hit_i = -1;
        fin_i = -1;
        rk.addr = l2_rsp_addr;
        rk.store = l2_rsp_store;
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            if (m_valid[i]) begin
                cnt++;
                if (s1_valid && (m_key[i] == s1_key)) hit_i = i;
                if (l2_rsp_valid && (m_key[i] == rk)) begin
                    if (!m_done[i]) fin_i = i;
                    else n_stale++;
                end
            end
        end
        e_full = (cnt + int'(s1_valid)) >= `MSHR_DEPTH;
        check_hit(2, mshr_hit, hit_slot, hit_i >= 0, slot_t'(hit_i));
        check_fin(3, mshr_fin, fin_slot, fin_i >= 0, slot_t'(fin_i));
        check_req(1, l2_req_valid, l2_req_addr, l2_req_store, l2_req_slot,
                  q_valid, q_key, q_slot);
        check_full(4, mshr_full, e_full);

        alloc = s1_valid && (hit_i < 0);
        retire = m_valid[m_head] && m_done[m_head];   // state before this edge
        if (hit_i >= 0) n_hit++;
        if (fin_i >= 0) begin
            n_fin++;
            m_done[fin_i] = 1'b1;
        end
        if (retire) begin
            m_valid[m_head] = 1'b0;
            m_done[m_head] = 1'b0;
            m_head = m_head + slot_t'(1);
        end
        w = slot_t'(alloc_cnt);
        q_valid = alloc;
        q_key = s1_key;
        q_slot = w;
        if (alloc) begin
            m_key[w] = s1_key;
            m_valid[w] = 1'b1;
            m_done[w] = 1'b0;
            alloc_cnt++;
            n_alloc++;
        end
        if (e_full) n_full++;
        if (miss_valid && e_full) n_drop++;
        s1_valid = miss_valid && !e_full;
        s1_key.addr = miss_addr;
        s1_key.store = (miss_op == OP_STORE);
    endtask

    initial begin
        #((N_CYCLES + 50) * 4);
        $display("timeout, the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int total_err;
        int total_chk;
        test_name = '{"reset", "allocation", "hit", "finish", "full and retire"};
        for (int t = 0; t < N_TESTS; t++) begin
            errors[t] = 0;
            checks[t] = 0;
        end
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            m_key[i].addr = 28'h0ab_e000 + addr_t'(i);   // outside the pool
            m_key[i].store = 1'b0;
            m_valid[i] = 1'b0;
            m_done[i] = 1'b0;
        end
        m_head = '0;
        alloc_cnt = 0;
        s1_valid = 1'b0;
        s1_key = '0;
        q_valid = 1'b0;
        q_key = '0;
        q_slot = '0;
        n_hit = 0;
        n_fin = 0;
        n_stale = 0;
        n_alloc = 0;
        n_full = 0;
        n_drop = 0;
        rst = 1'b1;
        // busy inputs while in reset
        miss_valid = 1'b1;
        miss_op = '0;
        miss_addr = POOL_BASE;
        l2_rsp_valid = 1'b1;
        l2_rsp_store = 1'b0;
        l2_rsp_addr = POOL_BASE;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        miss_valid = 1'b0;   // no new miss after reset
        @(negedge clk);
        check_hit(0, mshr_hit, hit_slot, 1'b0, '0);
        check_fin(0, mshr_fin, fin_slot, 1'b0, '0);
        check_req(0, l2_req_valid, l2_req_addr, l2_req_store, l2_req_slot, 1'b0, '0, '0);
        check_full(0, mshr_full, 1'b0);
        $display("test %s: %0d checks, %0d errors", test_name[0], checks[0], errors[0]);

        for (int c = 0; c < N_CYCLES; c++) begin
            @(posedge clk);
            #1;
            drive_random();
            @(negedge clk);
            model_cycle();
        end

        if (n_alloc == 0) note_failure(1, "no miss was ever allocated");
        if (n_hit == 0) note_failure(2, "no miss ever hit an outstanding entry");
        if (n_fin == 0) note_failure(3, "no L2 response ever finished an entry");
        if (n_stale == 0) note_failure(3, "no L2 response ever matched a finished entry");
        if (n_full == 0) note_failure(4, "the tracker never became full");
        if (n_drop == 0) note_failure(4, "no miss arrived while full");
        $display("test %s: %0d checks, %0d errors, %0d requests", test_name[1],
                 checks[1], errors[1], n_alloc);
        $display("test %s: %0d checks, %0d errors, %0d hits", test_name[2],
                 checks[2], errors[2], n_hit);
        $display("test %s: %0d checks, %0d errors, %0d finishes, %0d on done entries",
                 test_name[3], checks[3], errors[3], n_fin, n_stale);
        $display("test %s: %0d checks, %0d errors, %0d full cycles, %0d dropped",
                 test_name[4], checks[4], errors[4], n_full, n_drop);

        total_err = 0;
        total_chk = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_err += errors[t];
            total_chk += checks[t];
        end
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, total_chk, total_err);
        if (total_err == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
+incdir+tests
hw/mshr_pkg.sv
hw/miss_if.sv
hw/mshr_queue.sv
hw/mshr_track.sv
hw/miss_accept.sv
hw/l2_issue.sv
hw/mshr_top.sv
tests/mshr_tb.sv

//--- Makefile
TOP = mshr_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

obj_dir/V$(TOP): vlog.f hw/*.sv hw/*.svh tests/*.sv tests/*.svh
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir

# pass only when the testbench prints its pass line
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
